// File: rtl/idq_defs.svh
`ifndef IDQ_DEFS_SVH
`define IDQ_DEFS_SVH

// Width of the ID that every element carries
`define IDQ_ID_WIDTH 2

// Width of one stored element
`define IDQ_DATA_WIDTH 8

// Number of element cells, shared by all IDs
`define IDQ_CAPACITY 4

// There can never be more live IDs than distinct IDs or stored elements
`define IDQ_HT_CAPACITY ((1 << `IDQ_ID_WIDTH) < `IDQ_CAPACITY ? \
    (1 << `IDQ_ID_WIDTH) : `IDQ_CAPACITY)

// Index widths for the two tables
`define IDQ_LD_IDX_WIDTH $clog2(`IDQ_CAPACITY)
`define IDQ_HT_IDX_WIDTH $clog2(`IDQ_HT_CAPACITY)

`endif

// File: rtl/idq_pkg.sv
`default_nettype none

`include "idq_defs.svh"

package idq_pkg;

    // Element ID and element payload
    typedef logic [`IDQ_ID_WIDTH-1:0]     id_t;
    typedef logic [`IDQ_DATA_WIDTH-1:0]   data_t;

    // Index into the linked data table
    typedef logic [`IDQ_LD_IDX_WIDTH-1:0] ld_idx_t;

    // Index into the head-tail table
    typedef logic [`IDQ_HT_IDX_WIDTH-1:0] ht_idx_t;

    // One head-tail entry points at the oldest and newest cell of an ID
    typedef struct packed {
        id_t     id;
        ld_idx_t head;
        ld_idx_t tail;
        logic    free;
    } ht_entry_t;

    // A single write into the head-tail table, applied at the next edge
    typedef struct packed {
        logic      we;
        ht_idx_t   idx;
        ht_entry_t entry;
    } ht_cmd_t;

    // Updates to the linked data table for one cycle
    // Allocation always lands in the lowest free cell of the table
    typedef struct packed {
        logic    alloc_en;
        data_t   alloc_data;
        logic    link_en;
        ld_idx_t link_idx;
        logic    rel_en;
        ld_idx_t rel_idx;
    } ld_cmd_t;

endpackage

`default_nettype wire

// File: rtl/idq_head_tail.sv
`timescale 1ns/1ps
`default_nettype none

`include "idq_defs.svh"

module idq_head_tail
    import idq_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,

    // ID to look up in the table
    input  id_t     lookup_id_i,

    // Lookup result
    output logic    hit_o,
    output ht_idx_t hit_idx_o,
    output ld_idx_t hit_head_o,
    output ld_idx_t hit_tail_o,

    // Lowest entry that is not in use
    output ht_idx_t free_idx_o,

    // Write issued by the controller
    input  ht_cmd_t ht_cmd_i
);

    ht_entry_t [`IDQ_HT_CAPACITY-1:0] entries_q;
    logic      [`IDQ_HT_CAPACITY-1:0] match;

    // An entry matches only while it is occupied
    for (genvar i = 0; i < `IDQ_HT_CAPACITY; i++) begin : gen_match
        assign match[i] = !entries_q[i].free && (entries_q[i].id == lookup_id_i);
    end

    assign hit_o = |match;

    // At most one occupied entry holds a given ID, so the first match is the only one
    always_comb begin
        hit_idx_o  = '0;
        hit_head_o = '0;
        hit_tail_o = '0;
        for (int i = 0; i < `IDQ_HT_CAPACITY; i++) begin
            if (match[i]) begin
                hit_idx_o  = ht_idx_t'(i);
                hit_head_o = entries_q[i].head;
                hit_tail_o = entries_q[i].tail;
            end
        end
    end

    // Scan downwards so that the lowest free entry wins
    always_comb begin
        free_idx_o = '0;
        for (int i = `IDQ_HT_CAPACITY - 1; i >= 0; i--) begin
            if (entries_q[i].free) begin
                free_idx_o = ht_idx_t'(i);
            end
        end
    end

    // Every entry starts out free with its pointers cleared
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `IDQ_HT_CAPACITY; i++) begin
                entries_q[i] <= '{id: '0, head: '0, tail: '0, free: 1'b1};
            end
        end else if (ht_cmd_i.we) begin
            entries_q[ht_cmd_i.idx] <= ht_cmd_i.entry;
        end
    end

endmodule

`default_nettype wire

// File: rtl/idq_link_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "idq_defs.svh"

module idq_link_store
    import idq_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,

    // Combinational read of one cell
    input  ld_idx_t rd_idx_i,
    output data_t   rd_data_o,
    output ld_idx_t rd_next_o,

    // Allocation target and fill status
    output ld_idx_t free_idx_o,
    output logic    full_o,
    output logic    empty_o,

    // Updates issued by the controller
    input  ld_cmd_t ld_cmd_i
);

    data_t   [`IDQ_CAPACITY-1:0] data_q;
    ld_idx_t [`IDQ_CAPACITY-1:0] next_q;
    logic    [`IDQ_CAPACITY-1:0] free_q;

    assign rd_data_o = data_q[rd_idx_i];
    assign rd_next_o = next_q[rd_idx_i];

    // No free cell means the queue is full, and all free means it is empty
    assign full_o  = ~|free_q;
    assign empty_o = &free_q;

    // Lowest free cell is taken by the next allocation
    always_comb begin
        free_idx_o = '0;
        for (int i = `IDQ_CAPACITY - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                free_idx_o = ld_idx_t'(i);
            end
        end
    end

    // Free flags decide which cells hold live data
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            free_q <= '1;
        end else begin
            if (ld_cmd_i.alloc_en) begin
                free_q[free_idx_o] <= 1'b0;
            end
            if (ld_cmd_i.rel_en) begin
                free_q[ld_cmd_i.rel_idx] <= 1'b1;
            end
        end
    end

    // The allocated cell takes the pushed element
    always_ff @(posedge clk_i) begin
        if (ld_cmd_i.alloc_en) begin
            data_q[free_idx_o] <= ld_cmd_i.alloc_data;
        end
        // The old tail now points at the cell that is being allocated
        if (ld_cmd_i.link_en) begin
            next_q[ld_cmd_i.link_idx] <= free_idx_o;
        end
    end

endmodule

`default_nettype wire

// File: rtl/idq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module idq_ctrl
    import idq_pkg::*;
(
    // Input port
    input  id_t     inp_id_i,
    input  data_t   inp_data_i,
    input  logic    inp_req_i,
    output logic    inp_gnt_o,

    // Output port
    input  id_t     oup_id_i,
    input  logic    oup_pop_i,
    input  logic    oup_req_i,
    output logic    oup_gnt_o,
    output data_t   oup_data_o,
    output logic    oup_data_valid_o,

    // Head-tail lookup
    output id_t     lookup_id_o,
    input  logic    hit_i,
    input  ht_idx_t hit_idx_i,
    input  ld_idx_t hit_head_i,
    input  ld_idx_t hit_tail_i,
    input  ht_idx_t ht_free_idx_i,

    // Link store read and status
    output ld_idx_t rd_idx_o,
    input  data_t   rd_data_i,
    input  ld_idx_t rd_next_i,
    input  ld_idx_t ld_free_idx_i,
    input  logic    full_i,

    // Table updates for the next edge
    output ht_cmd_t ht_cmd_o,
    output ld_cmd_t ld_cmd_o
);

    logic push;

    // The input port wins whenever there is room for another element
    assign inp_gnt_o = !full_i;
    assign push      = inp_req_i && !full_i;
    assign oup_gnt_o = oup_req_i && !push;

    // Only one port uses the lookup in a given cycle
    assign lookup_id_o = push ? inp_id_i : oup_id_i;

    // The head cell of the looked-up ID is the one to read or pop
    assign rd_idx_o = hit_head_i;

    always_comb begin
        oup_data_o       = '0;
        oup_data_valid_o = 1'b0;
        ht_cmd_o         = '0;
        ld_cmd_o         = '0;

        if (push) begin
            // The new element always goes into the lowest free cell
            ld_cmd_o.alloc_en   = 1'b1;
            ld_cmd_o.alloc_data = inp_data_i;
            ht_cmd_o.we         = 1'b1;
            if (hit_i) begin
                // Known ID, so append behind the current tail
                ld_cmd_o.link_en = 1'b1;
                ld_cmd_o.link_idx = hit_tail_i;
                ht_cmd_o.idx     = hit_idx_i;
                ht_cmd_o.entry   = '{id: inp_id_i, head: hit_head_i,
                                     tail: ld_free_idx_i, free: 1'b0};
            end else begin
                // First element of this ID opens a new head-tail entry
                ht_cmd_o.idx   = ht_free_idx_i;
                ht_cmd_o.entry = '{id: inp_id_i, head: ld_free_idx_i,
                                   tail: ld_free_idx_i, free: 1'b0};
            end
        end else if (oup_gnt_o && hit_i) begin
            // A miss is still granted but returns no valid data
            oup_data_o       = rd_data_i;
            oup_data_valid_o = 1'b1;
            if (oup_pop_i) begin
                ld_cmd_o.rel_en  = 1'b1;
                ld_cmd_o.rel_idx = hit_head_i;
                ht_cmd_o.we      = 1'b1;
                ht_cmd_o.idx     = hit_idx_i;
                if (hit_head_i == hit_tail_i) begin
                    // Last element of this ID, so the entry goes back to the pool
                    ht_cmd_o.entry = '{id: '0, head: '0, tail: '0, free: 1'b1};
                end else begin
                    ht_cmd_o.entry = '{id: oup_id_i, head: rd_next_i,
                                       tail: hit_tail_i, free: 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/id_queue.sv
`timescale 1ns/1ps
`default_nettype none

module id_queue
    import idq_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,

    // Push side
    input  id_t   inp_id_i,
    input  data_t inp_data_i,
    input  logic  inp_req_i,
    output logic  inp_gnt_o,

    // Read and pop side
    input  id_t   oup_id_i,
    input  logic  oup_pop_i,
    input  logic  oup_req_i,
    output logic  oup_gnt_o,
    output data_t oup_data_o,
    output logic  oup_data_valid_o,

    // Status
    output logic  full_o,
    output logic  empty_o
);

    id_t     lookup_id;
    logic    hit;
    ht_idx_t hit_idx;
    ld_idx_t hit_head;
    ld_idx_t hit_tail;
    ht_idx_t ht_free_idx;
    ld_idx_t rd_idx;
    data_t   rd_data;
    ld_idx_t rd_next;
    ld_idx_t ld_free_idx;
    ht_cmd_t ht_cmd;
    ld_cmd_t ld_cmd;

    // Arbitration and command generation
    idq_ctrl u_ctrl (
        .inp_id_i         (inp_id_i),
        .inp_data_i       (inp_data_i),
        .inp_req_i        (inp_req_i),
        .inp_gnt_o        (inp_gnt_o),
        .oup_id_i         (oup_id_i),
        .oup_pop_i        (oup_pop_i),
        .oup_req_i        (oup_req_i),
        .oup_gnt_o        (oup_gnt_o),
        .oup_data_o       (oup_data_o),
        .oup_data_valid_o (oup_data_valid_o),
        .lookup_id_o      (lookup_id),
        .hit_i            (hit),
        .hit_idx_i        (hit_idx),
        .hit_head_i       (hit_head),
        .hit_tail_i       (hit_tail),
        .ht_free_idx_i    (ht_free_idx),
        .rd_idx_o         (rd_idx),
        .rd_data_i        (rd_data),
        .rd_next_i        (rd_next),
        .ld_free_idx_i    (ld_free_idx),
        .full_i           (full_o),
        .ht_cmd_o         (ht_cmd),
        .ld_cmd_o         (ld_cmd)
    );

    // Per-ID head and tail pointers
    idq_head_tail u_head_tail (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lookup_id_i (lookup_id),
        .hit_o       (hit),
        .hit_idx_o   (hit_idx),
        .hit_head_o  (hit_head),
        .hit_tail_o  (hit_tail),
        .free_idx_o  (ht_free_idx),
        .ht_cmd_i    (ht_cmd)
    );

    // Element cells chained into one list per ID
    idq_link_store u_link_store (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rd_idx_i   (rd_idx),
        .rd_data_o  (rd_data),
        .rd_next_o  (rd_next),
        .free_idx_o (ld_free_idx),
        .full_o     (full_o),
        .empty_o    (empty_o),
        .ld_cmd_i   (ld_cmd)
    );

endmodule

`default_nettype wire

// File: dv/id_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "idq_defs.svh"

module id_queue_tb
    import idq_pkg::*;
;

    localparam int CLK_PERIOD     = 40;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int NUM_IDS        = 1 << `IDQ_ID_WIDTH;

    logic  clk_i;
    logic  rst_ni;
    id_t   inp_id_i;
    data_t inp_data_i;
    logic  inp_req_i;
    logic  inp_gnt_o;
    id_t   oup_id_i;
    logic  oup_pop_i;
    logic  oup_req_i;
    logic  oup_gnt_o;
    data_t oup_data_o;
    logic  oup_data_valid_o;
    logic  full_o;
    logic  empty_o;

    // Reference model keeps one FIFO per ID, with the oldest element at slot 0
    data_t model_mem [NUM_IDS][`IDQ_CAPACITY];
    int    model_cnt [NUM_IDS];
    int    seed;
    string test_name;

    id_queue UUT (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .inp_id_i         (inp_id_i),
        .inp_data_i       (inp_data_i),
        .inp_req_i        (inp_req_i),
        .inp_gnt_o        (inp_gnt_o),
        .oup_id_i         (oup_id_i),
        .oup_pop_i        (oup_pop_i),
        .oup_req_i        (oup_req_i),
        .oup_gnt_o        (oup_gnt_o),
        .oup_data_o       (oup_data_o),
        .oup_data_valid_o (oup_data_valid_o),
        .full_o           (full_o),
        .empty_o          (empty_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch in %s", test_name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s: %s never came within %0d cycles",
                 test_name, what, TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1, "Wait expired");
    endtask

    // Pushes one element and records it in the model once it is granted
    task automatic push_elem(input id_t id, input data_t data);
        int cycles;
        @(negedge clk_i);
        inp_id_i   = id;
        inp_data_i = data;
        inp_req_i  = 1'b1;
        cycles     = 0;
        #1;
        while (!inp_gnt_o) begin
            if (cycles == TIMEOUT_CYCLES) report_timeout("the input grant");
            @(negedge clk_i);
            #1;
            cycles++;
        end
        model_mem[id][model_cnt[id]] = data;
        model_cnt[id]++;
        @(negedge clk_i);
        inp_req_i = 1'b0;
    endtask

    // One output request, checked against the oldest model element of the ID
    task automatic request_output(input id_t id, input logic pop);
        int cycles;
        @(negedge clk_i);
        oup_id_i  = id;
        oup_pop_i = pop;
        oup_req_i = 1'b1;
        cycles    = 0;
        #1;
        while (!oup_gnt_o) begin
            if (cycles == TIMEOUT_CYCLES) report_timeout("the output grant");
            @(negedge clk_i);
            #1;
            cycles++;
        end
        check_value("data valid", model_cnt[id] != 0, oup_data_valid_o);
        if (model_cnt[id] != 0) begin
            check_value("data", model_mem[id][0], oup_data_o);
            if (pop) begin
                // Shift the remaining elements of this ID forward
                for (int i = 1; i < model_cnt[id]; i++) begin
                    model_mem[id][i-1] = model_mem[id][i];
                end
                model_cnt[id]--;
            end
        end
        @(negedge clk_i);
        oup_req_i = 1'b0;
        oup_pop_i = 1'b0;
    endtask

    task automatic read_elem(input id_t id);
        request_output(id, 1'b0);
    endtask

    task automatic pop_elem(input id_t id);
        request_output(id, 1'b1);
    endtask

    task automatic test_reset_state();
        test_name = "reset_state";
        check_value("empty", 1, empty_o);
        check_value("full", 0, full_o);
        check_value("input grant", 1, inp_gnt_o);
        for (int i = 0; i < NUM_IDS; i++) begin
            read_elem(id_t'(i));
        end
    endtask

    task automatic test_interleaved_ids();
        id_t order [8] = '{1, 2, 1, 2, 0, 3, 0, 0};
        test_name = "interleaved_ids";
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < 4; i++) begin
                push_elem(order[round*4 + i], data_t'($random(seed)));
            end
            // Pop in a different ID order than the pushes
            for (int i = 3; i >= 0; i--) begin
                pop_elem(order[round*4 + i]);
            end
        end
        check_value("empty", 1, empty_o);
    endtask

    task automatic test_read_no_pop();
        test_name = "read_no_pop";
        push_elem(3, data_t'($random(seed)));
        push_elem(3, data_t'($random(seed)));
        read_elem(3);
        read_elem(3);
        pop_elem(3);
        read_elem(3);
        pop_elem(3);
        read_elem(3);
    endtask

    task automatic test_full_queue();
        id_t ids [4] = '{0, 1, 0, 2};
        test_name = "full_queue";
        for (int i = 0; i < `IDQ_CAPACITY; i++) begin
            push_elem(ids[i], data_t'($random(seed)));
        end
        check_value("full", 1, full_o);
        check_value("input grant", 0, inp_gnt_o);
        // This push must be refused and leave ID 3 absent
        @(negedge clk_i);
        inp_id_i   = 3;
        inp_data_i = 8'hee;
        inp_req_i  = 1'b1;
        #1;
        check_value("grant when full", 0, inp_gnt_o);
        @(negedge clk_i);
        inp_req_i = 1'b0;
        read_elem(3);
        pop_elem(0);
        check_value("grant after pop", 1, inp_gnt_o);
        pop_elem(1);
        pop_elem(0);
        pop_elem(2);
        check_value("empty", 1, empty_o);
    endtask

    task automatic test_push_priority();
        data_t data;
        test_name = "push_priority";
        push_elem(1, data_t'($random(seed)));
        data = data_t'($random(seed));
        @(negedge clk_i);
        inp_id_i   = 1;
        inp_data_i = data;
        inp_req_i  = 1'b1;
        oup_id_i   = 1;
        oup_pop_i  = 1'b1;
        oup_req_i  = 1'b1;
        #1;
        check_value("input grant", 1, inp_gnt_o);
        check_value("output grant", 0, oup_gnt_o);
        model_mem[1][model_cnt[1]] = data;
        model_cnt[1]++;
        @(negedge clk_i);
        inp_req_i = 1'b0;
        oup_req_i = 1'b0;
        oup_pop_i = 1'b0;
        pop_elem(1);
        read_elem(1);
        pop_elem(1);
        check_value("empty", 1, empty_o);
    endtask

    initial begin
        seed        = 95;
        rst_ni      = 1'b0;
        inp_id_i    = '0;
        inp_data_i  = '0;
        inp_req_i   = 1'b0;
        oup_id_i    = '0;
        oup_pop_i   = 1'b0;
        oup_req_i   = 1'b0;
        for (int i = 0; i < NUM_IDS; i++) begin
            model_cnt[i] = 0;
        end
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        test_reset_state();
        test_interleaved_ids();
        test_read_no_pop();
        test_full_queue();
        test_push_priority();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+rtl
rtl/idq_pkg.sv
rtl/idq_head_tail.sv
rtl/idq_link_store.sv
rtl/idq_ctrl.sv
rtl/id_queue.sv
dv/id_queue_tb.sv
